// ==== list.f ====
rtl/fetch_pkg.sv
rtl/line_fill.sv
rtl/branch_target_buffer.sv
rtl/fetch_ctrl.sv
rtl/inst_queue.sv
rtl/fetch_frontend.sv
verif/fetch_frontend_asserts.sv
verif/tb_fetch_frontend.sv

// ==== rtl/branch_target_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_INDEX_BITS = 4
) (
    input  wire logic                          clk,
    input  wire logic                          rst,

    input  wire logic [fetch_pkg::XLEN-1:0]    lookup_pc_i,
    output logic                               hit_o,
    output logic      [fetch_pkg::XLEN-1:0]    target_o,

    input  wire logic                          train_i,
    input  wire fetch_pkg::redirect_t          train_data_i
);

    localparam int ENTRIES = 2 ** BTB_INDEX_BITS;
    localparam int TAG_LSB = BTB_INDEX_BITS + 2;   // word aligned pcs
    localparam int TAG_W   = fetch_pkg::XLEN - TAG_LSB;

    typedef struct packed {
        logic [TAG_W-1:0]           tag;
        logic [fetch_pkg::XLEN-1:0] target;
    } btb_entry_t;

    logic [ENTRIES-1:0]         valid_q;
    btb_entry_t                 table_q [ENTRIES];

    logic [BTB_INDEX_BITS-1:0]  rd_idx;
    logic [BTB_INDEX_BITS-1:0]  wr_idx;
    btb_entry_t                 rd_entry;

    assign rd_idx   = lookup_pc_i[TAG_LSB-1:2];
    assign wr_idx   = train_data_i.branch_pc[TAG_LSB-1:2];
    assign rd_entry = table_q[rd_idx];

    // combinational lookup
    assign hit_o    = valid_q[rd_idx] && (rd_entry.tag == lookup_pc_i[fetch_pkg::XLEN-1:TAG_LSB]);
    assign target_o = rd_entry.target;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (train_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (train_i) begin
            table_q[wr_idx].tag    <= train_data_i.branch_pc[fetch_pkg::XLEN-1:TAG_LSB];
            table_q[wr_idx].target <= train_data_i.target;
        end
    end

endmodule : branch_target_buffer

`default_nettype wire

// ==== rtl/fetch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl (
    input  wire logic                          clk,
    input  wire logic                          rst,

    input  wire logic                          redirect_i,
    input  wire fetch_pkg::redirect_t          redirect_data_i,

    input  wire logic                          fill_done_i,
    input  wire logic [fetch_pkg::LINE_W-1:0]  fill_line_i,
    input  wire logic [fetch_pkg::XLEN-1:0]    fill_line_addr_i,
    output logic                               fill_req_o,
    output logic      [fetch_pkg::XLEN-1:0]    fill_addr_o,

    output logic      [fetch_pkg::XLEN-1:0]    btb_pc_o,
    input  wire logic                          btb_hit_i,
    input  wire logic [fetch_pkg::XLEN-1:0]    btb_target_i,

    input  wire logic                          queue_full_i,
    output logic                               enq_o,
    output fetch_pkg::fetch_entry_t            enq_data_o
);

    localparam int OFS   = fetch_pkg::LINE_OFFSET_BITS;
    localparam int TAG_W = fetch_pkg::XLEN - OFS;
    localparam int WORDS = fetch_pkg::LINE_W / fetch_pkg::XLEN;

    logic [fetch_pkg::XLEN-1:0]    pc_q;
    logic [fetch_pkg::XLEN-1:0]    pc_next;
    logic [fetch_pkg::LINE_W-1:0]  line_q;
    logic [TAG_W-1:0]              line_tag_q;
    logic                          line_valid_q;
    logic                          wait_q;       // fill outstanding

    logic                          line_hit;
    logic [fetch_pkg::XLEN-1:0]    inst;
    logic                          is_cf_op;
    logic [$clog2(WORDS)-1:0]      word_sel;

    assign line_hit = line_valid_q && (line_tag_q == pc_q[fetch_pkg::XLEN-1:OFS]);

    // word within the line
    assign word_sel = pc_q[OFS-1:2];
    assign inst     = line_q[word_sel*fetch_pkg::XLEN +: fetch_pkg::XLEN];

    assign is_cf_op = inst[6:0] inside {fetch_pkg::OP_JAL, fetch_pkg::OP_JALR,
                                        fetch_pkg::OP_BRANCH};

    // one request per miss, none while the pc is being replaced
    assign fill_req_o  = !line_hit && !wait_q && !redirect_i;
    assign fill_addr_o = {pc_q[fetch_pkg::XLEN-1:OFS], {OFS{1'b0}}};

    assign btb_pc_o = pc_q;

    assign enq_o           = line_hit && !queue_full_i && !redirect_i;
    assign enq_data_o.pc   = pc_q;
    assign enq_data_o.inst = inst;

    always_comb begin
        pc_next = pc_q;   // hold on miss or full queue
        if (redirect_i) begin
            pc_next = redirect_data_i.target;
        end else if (enq_o) begin
            if (btb_hit_i && is_cf_op) begin
                pc_next = btb_target_i;
            end else begin
                pc_next = pc_q + fetch_pkg::XLEN'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q         <= fetch_pkg::RESET_PC;
            line_valid_q <= 1'b0;
            wait_q       <= 1'b0;
        end else begin
            pc_q <= pc_next;
            if (fill_done_i) begin
                line_valid_q <= 1'b1;
                wait_q       <= 1'b0;
            end else if (fill_req_o) begin
                wait_q <= 1'b1;
            end
        end
    end

    // a fill still lands after a redirect
    always_ff @(posedge clk) begin
        if (fill_done_i) begin
            line_q     <= fill_line_i;
            line_tag_q <= fill_line_addr_i[fetch_pkg::XLEN-1:OFS];
        end
    end

endmodule : fetch_ctrl

`default_nettype wire

// ==== rtl/fetch_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend #(
    parameter int QUEUE_DEPTH    = 8,
    parameter int BTB_INDEX_BITS = 4
) (
    input  wire logic                          clk,
    input  wire logic                          rst,

    // backing memory, read only
    input  wire logic                          bmem_ready_i,
    input  wire logic [fetch_pkg::BEAT_W-1:0]  bmem_rdata_i,
    input  wire logic                          bmem_rvalid_i,
    output logic                               bmem_read_o,
    output logic      [fetch_pkg::XLEN-1:0]    bmem_addr_o,

    input  wire logic                          redirect_i,
    input  wire fetch_pkg::redirect_t          redirect_data_i,

    // consumer side
    input  wire logic                          deq_i,
    output logic                               inst_valid_o,
    output fetch_pkg::fetch_entry_t            inst_o
);

    logic                           fill_req;
    logic [fetch_pkg::XLEN-1:0]     fill_addr;
    logic                           fill_done;
    logic [fetch_pkg::LINE_W-1:0]   fill_line;
    logic [fetch_pkg::XLEN-1:0]     fill_line_addr;

    logic [fetch_pkg::XLEN-1:0]     btb_pc;
    logic                           btb_hit;
    logic [fetch_pkg::XLEN-1:0]     btb_target;

    logic                           enq;
    fetch_pkg::fetch_entry_t        enq_data;
    logic                           queue_full;

    line_fill u_line_fill (
        .clk              (clk),
        .rst              (rst),
        .fill_req_i       (fill_req),
        .fill_addr_i      (fill_addr),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_rvalid_i    (bmem_rvalid_i),
        .bmem_read_o      (bmem_read_o),
        .bmem_addr_o      (bmem_addr_o),
        .fill_done_o      (fill_done),
        .fill_line_o      (fill_line),
        .fill_line_addr_o (fill_line_addr)
    );

    branch_target_buffer #(
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_btb (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc_i  (btb_pc),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .train_i      (redirect_i),     // every redirect trains
        .train_data_i (redirect_data_i)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk              (clk),
        .rst              (rst),
        .redirect_i       (redirect_i),
        .redirect_data_i  (redirect_data_i),
        .fill_done_i      (fill_done),
        .fill_line_i      (fill_line),
        .fill_line_addr_i (fill_line_addr),
        .fill_req_o       (fill_req),
        .fill_addr_o      (fill_addr),
        .btb_pc_o         (btb_pc),
        .btb_hit_i        (btb_hit),
        .btb_target_i     (btb_target),
        .queue_full_i     (queue_full),
        .enq_o            (enq),
        .enq_data_o       (enq_data)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (redirect_i),
        .enq_i      (enq),
        .enq_data_i (enq_data),
        .deq_i      (deq_i),
        .head_o     (inst_o),
        .valid_o    (inst_valid_o),
        .full_o     (queue_full)
    );

endmodule : fetch_frontend

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // datapath and address width
    localparam int XLEN = 32;

    // backing memory returns one line as a burst of beats
    localparam int BEAT_W           = 64;
    localparam int BEATS_PER_LINE   = 4;
    localparam int LINE_W           = BEAT_W * BEATS_PER_LINE;   // 256 bits
    localparam int LINE_OFFSET_BITS = 5;                         // 32 bytes per line

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h1eceb000;

    // control-flow opcodes that the btb may steer
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // one fetched instruction with its address
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_entry_t;

    // resolved control flow from the back end
    typedef struct packed {
        logic [XLEN-1:0] branch_pc;  // pc of the control-flow instruction
        logic [XLEN-1:0] target;     // where fetch continues
    } redirect_t;

endpackage : fetch_pkg

`default_nettype wire

// ==== rtl/inst_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     flush_i,
    input  wire logic                     enq_i,
    input  wire fetch_pkg::fetch_entry_t  enq_data_i,
    input  wire logic                     deq_i,

    output fetch_pkg::fetch_entry_t       head_o,
    output logic                          valid_o,
    output logic                          full_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(QUEUE_DEPTH);

    fetch_pkg::fetch_entry_t  mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0]         head_q;
    logic [PTR_W-1:0]         tail_q;
    logic [CNT_W-1:0]         count_q;
    logic                     do_enq;
    logic                     do_deq;

    assign valid_o = (count_q != '0);
    assign full_o  = (count_q == FULL_COUNT);
    assign head_o  = mem_q[head_q];

    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && valid_o;   // empty dequeue ignored

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_enq) begin
                tail_q <= (tail_q == LAST_PTR) ? '0 : tail_q + PTR_W'(1);
            end
            if (do_deq) begin
                head_q <= (head_q == LAST_PTR) ? '0 : head_q + PTR_W'(1);
            end
            if (do_enq && !do_deq) begin
                count_q <= count_q + CNT_W'(1);
            end else if (do_deq && !do_enq) begin
                count_q <= count_q - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem_q[tail_q] <= enq_data_i;
        end
    end

endmodule : inst_queue

`default_nettype wire

// ==== rtl/line_fill.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_fill (
    input  wire logic                          clk,
    input  wire logic                          rst,

    input  wire logic                          fill_req_i,
    input  wire logic [fetch_pkg::XLEN-1:0]    fill_addr_i,

    input  wire logic                          bmem_ready_i,
    input  wire logic [fetch_pkg::BEAT_W-1:0]  bmem_rdata_i,
    input  wire logic                          bmem_rvalid_i,
    output logic                               bmem_read_o,
    output logic      [fetch_pkg::XLEN-1:0]    bmem_addr_o,

    output logic                               fill_done_o,
    output logic      [fetch_pkg::LINE_W-1:0]  fill_line_o,
    output logic      [fetch_pkg::XLEN-1:0]    fill_line_addr_o
);

    localparam int CNT_W = $clog2(fetch_pkg::BEATS_PER_LINE);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(fetch_pkg::BEATS_PER_LINE - 1);

    logic                            busy;      // request accepted, line not complete
    logic                            req_pend;  // strobe not yet sent to memory
    logic [CNT_W-1:0]                beat_cnt;
    logic                            done_q;
    logic [fetch_pkg::XLEN-1:0]      addr_q;
    logic [fetch_pkg::LINE_W-1:0]    line_q;

    // strobe only goes out while memory can take it
    assign bmem_read_o = req_pend & bmem_ready_i;
    assign bmem_addr_o = addr_q;

    assign fill_done_o      = done_q;
    assign fill_line_o      = line_q;
    assign fill_line_addr_o = addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            req_pend <= 1'b0;
            beat_cnt <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy && fill_req_i) begin
                busy     <= 1'b1;
                req_pend <= 1'b1;
                beat_cnt <= '0;
            end
            if (bmem_read_o) begin
                req_pend <= 1'b0;
            end
            if (busy && !req_pend && bmem_rvalid_i) begin
                beat_cnt <= beat_cnt + CNT_W'(1);
                if (beat_cnt == LAST_BEAT) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // payload, lowest beat ends up in the low bits
    always_ff @(posedge clk) begin
        if (!busy && fill_req_i) begin
            addr_q <= {fill_addr_i[fetch_pkg::XLEN-1:fetch_pkg::LINE_OFFSET_BITS],
                       {fetch_pkg::LINE_OFFSET_BITS{1'b0}}};
        end
        if (busy && !req_pend && bmem_rvalid_i) begin
            line_q <= {bmem_rdata_i, line_q[fetch_pkg::LINE_W-1:fetch_pkg::BEAT_W]};
        end
    end

endmodule : line_fill

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_frontend -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# allow the bound assertions to report before the testbench stops the run
out="$(./obj_dir/Vtb_fetch_frontend +verilator+error+limit+100 2>&1)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// ==== verif/fetch_frontend_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend_asserts (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        bmem_ready_i,
    input  wire logic                        bmem_rvalid_i,
    input  wire logic                        bmem_read_o,
    input  wire logic [fetch_pkg::XLEN-1:0]  bmem_addr_o,
    input  wire logic                        redirect_i,
    input  wire logic                        inst_valid_o
);

    logic [2:0] beats_owed;          // beats still due for the last request
    logic       read_bad    = 1'b0;
    logic       overlap_bad = 1'b0;
    logic       flush_bad   = 1'b0;
    logic       any_fail;            // sticky, polled by the testbench

    assign any_fail = read_bad | overlap_bad | flush_bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_owed <= '0;
        end else if (bmem_read_o) begin
            beats_owed <= 3'd4;
        end else if (bmem_rvalid_i && beats_owed != 3'd0) begin
            beats_owed <= beats_owed - 3'd1;
        end
    end

    // request goes out line aligned and only while memory is ready
    read_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> (bmem_addr_o[fetch_pkg::LINE_OFFSET_BITS-1:0] == '0) && bmem_ready_i)
    else begin
        $error("line read misaligned or issued without bmem_ready_i");
        read_bad = 1'b1;
    end

    read_spacing: assert property (@(posedge clk) disable iff (rst)
        bmem_read_o |-> (beats_owed == 3'd0))
    else begin
        $error("new line read before four beats of the previous one");
        overlap_bad = 1'b1;
    end

    // queue is emptied by the redirect edge
    redirect_flush: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> !inst_valid_o)
    else begin
        $error("inst_valid_o high on the cycle after redirect_i");
        flush_bad = 1'b1;
    end

endmodule : fetch_frontend_asserts

bind fetch_frontend fetch_frontend_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .bmem_ready_i  (bmem_ready_i),
    .bmem_rvalid_i (bmem_rvalid_i),
    .bmem_read_o   (bmem_read_o),
    .bmem_addr_o   (bmem_addr_o),
    .redirect_i    (redirect_i),
    .inst_valid_o  (inst_valid_o)
);

`default_nettype wire

// ==== verif/tb_fetch_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_frontend;

    localparam int QUEUE_DEPTH    = 8;
    localparam int BTB_INDEX_BITS = 4;
    localparam int BTB_ENTRIES    = 2 ** BTB_INDEX_BITS;
    localparam int NUM_DEQ        = 2000;
    localparam int STALL_LIMIT    = 200;
    localparam int HOLD_PERIOD    = 320;   // consumer stalls to fill the queue
    localparam int HOLD_CYCLES    = 40;
    localparam logic [6:0] OP_ADDI = 7'b0010011;

    logic                           clk;
    logic                           rst;
    logic                           bmem_ready_i;
    logic [fetch_pkg::BEAT_W-1:0]   bmem_rdata_i;
    logic                           bmem_rvalid_i;
    logic                           bmem_read_o;
    logic [fetch_pkg::XLEN-1:0]     bmem_addr_o;
    logic                           redirect_i;
    fetch_pkg::redirect_t           redirect_data_i;
    logic                           deq_i;
    logic                           inst_valid_o;
    fetch_pkg::fetch_entry_t        inst_o;

    logic [15:0]  lfsr_state;
    logic         ref_valid  [BTB_ENTRIES];   // reference btb holding one pc per index
    logic [31:0]  ref_pc     [BTB_ENTRIES];
    logic [31:0]  ref_target [BTB_ENTRIES];

    fetch_frontend #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .BTB_INDEX_BITS (BTB_INDEX_BITS)
    ) u_dut (
        .clk             (clk),
        .rst             (rst),
        .bmem_ready_i    (bmem_ready_i),
        .bmem_rdata_i    (bmem_rdata_i),
        .bmem_rvalid_i   (bmem_rvalid_i),
        .bmem_read_o     (bmem_read_o),
        .bmem_addr_o     (bmem_addr_o),
        .redirect_i      (redirect_i),
        .redirect_data_i (redirect_data_i),
        .deq_i           (deq_i),
        .inst_valid_o    (inst_valid_o),
        .inst_o          (inst_o)
    );

    // galois lfsr stepped once per bit
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hb400 : 16'h0000);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // two jal slots in every 128 byte block
    function automatic logic is_jal(input logic [31:0] addr);
        return (addr[6:2] == 5'd15) || (addr[6:2] == 5'd26);
    endfunction

    function automatic logic [31:0] image_word(input logic [31:0] addr);
        if (is_jal(addr)) begin
            return {addr[21:2], 5'd0, fetch_pkg::OP_JAL};
        end
        return {addr[13:2], 5'd1, 3'b000, 5'd1, OP_ADDI};   // addi x1, x1, imm
    endfunction

    function automatic logic [63:0] beat_data(input logic [31:0] line_addr, input int beat);
        logic [31:0] a;
        a = line_addr + 32'(beat * 8);
        return {image_word(a + 32'd4), image_word(a)};
    endfunction

    task automatic end_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end_with_failure();
    endtask

    task automatic report_error(input string what);
        $display("ERROR t=%0t %s", $time, what);
        end_with_failure();
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : stimulus
        fetch_pkg::fetch_entry_t head;
        logic [31:0] exp_pc;
        logic [31:0] tgt;
        logic [31:0] mem_addr;
        logic [7:0]  r;
        logic        mem_busy;
        logic        redirecting;
        logic        hold;
        int          deq_count;
        int          stall;
        int          cycle;
        int          mem_wait;
        int          mem_beat;
        int          idx;

        rst             = 1'b1;
        bmem_ready_i    = 1'b1;
        bmem_rdata_i    = '0;
        bmem_rvalid_i   = 1'b0;
        redirect_i      = 1'b0;
        redirect_data_i = '0;
        deq_i           = 1'b0;
        lfsr_state      = 16'd22;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
        end
        exp_pc    = fetch_pkg::RESET_PC;
        mem_busy  = 1'b0;
        mem_wait  = 0;
        mem_beat  = 0;
        mem_addr  = '0;
        deq_count = 0;
        stall     = 0;
        cycle     = 0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!inst_valid_o) else report_mismatch("inst_valid_o", 32'd0, 32'(inst_valid_o));
        assert (!bmem_read_o) else report_mismatch("bmem_read_o", 32'd0, 32'(bmem_read_o));

        while (deq_count < NUM_DEQ) begin
            @(posedge clk);
            cycle++;
            assert (!u_dut.u_asserts.any_fail)
                else report_error("a protocol assertion on fetch_frontend failed");

            // memory model with one line in flight
            if (bmem_read_o) begin
                mem_addr = bmem_addr_o;
                r        = take_bits(3);
                mem_wait = 1 + int'(r) % 6;
                mem_beat = 0;
                mem_busy = 1'b1;
            end
            if (mem_busy && mem_wait > 0) begin
                mem_wait--;
                bmem_rvalid_i <= 1'b0;
            end else if (mem_busy) begin
                bmem_rvalid_i <= 1'b1;
                bmem_rdata_i  <= beat_data(mem_addr, mem_beat);   // lowest beat first
                mem_beat++;
                mem_busy = (mem_beat < fetch_pkg::BEATS_PER_LINE);
            end else begin
                bmem_rvalid_i <= 1'b0;
            end
            r = take_bits(2);
            bmem_ready_i <= (r != 8'd0);

            redirect_i  <= 1'b0;
            redirecting = 1'b0;
            if (deq_i && inst_valid_o) begin
                head = inst_o;
                assert (head.pc == exp_pc) else report_mismatch("inst_o.pc", exp_pc, head.pc);
                assert (head.inst == image_word(head.pc))
                    else report_mismatch("inst_o.inst", image_word(head.pc), head.inst);
                deq_count++;
                stall = 0;
                idx = int'(head.pc[BTB_INDEX_BITS+1:2]);
                if (is_jal(head.pc) && ref_valid[idx] && ref_pc[idx] == head.pc) begin
                    exp_pc = ref_target[idx];   // trained jal is followed
                end else begin
                    exp_pc = head.pc + 32'd4;
                end
                r = take_bits(1);
                if (is_jal(head.pc) && r[0]) begin
                    r   = take_bits(4);
                    tgt = fetch_pkg::RESET_PC + {22'd0, r[3:0], 6'd0};
                    redirect_i      <= 1'b1;
                    redirect_data_i <= '{branch_pc: head.pc, target: tgt};
                    ref_valid[idx]  = 1'b1;   // evicts any colliding pc
                    ref_pc[idx]     = head.pc;
                    ref_target[idx] = tgt;
                    exp_pc      = tgt;
                    redirecting = 1'b1;
                end
            end else begin
                stall++;
                assert (stall < STALL_LIMIT)
                    else report_error("no instruction dequeued within the stall limit");
            end

            hold = (cycle % HOLD_PERIOD) < HOLD_CYCLES;
            r = take_bits(2);
            deq_i <= !redirecting && !hold && (r != 8'd0);
        end

        // bound assertions of the last edge have settled by now
        @(negedge clk);
        if (u_dut.u_asserts.any_fail) begin
            report_error("a protocol assertion on fetch_frontend failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule : tb_fetch_frontend

`default_nettype wire
